/* rtl/rv_pkg.sv */
package rv_pkg;

  // --------------------
  // Widths and sizes
  // --------------------

  localparam int xlen = 32;
  localparam int imem_aw = 8;
  localparam int imem_depth = 1 << imem_aw;
  localparam int nregs = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // PC advance per instruction
  localparam word_t pc_step = 4;

  // --------------------
  // Encodings
  // --------------------

  localparam logic [6:0] opc_op = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui = 7'b0110111;
  localparam logic [6:0] opc_auipc = 7'b0010111;

  // Full word, not just the opcode
  localparam logic [31:0] instr_ebreak = 32'h0010_0073;

  typedef enum logic [1:0] {
    cls_add_only = 2'd0,
    cls_reg_op   = 2'd1,
    cls_imm_op   = 2'd2
  } alu_class_e;

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_sll  = 4'd2,
    alu_slt  = 4'd3,
    alu_sltu = 4'd4,
    alu_xor  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_or   = 4'd8,
    alu_and  = 4'd9
  } alu_op_e;

  typedef enum logic [1:0] {
    a_rs1  = 2'd0,
    a_zero = 2'd1,
    a_pc   = 2'd2
  } a_src_e;

  // --------------------
  // Shared structs
  // --------------------

  typedef struct packed {
    logic       reg_write;
    logic       b_is_imm;
    a_src_e     a_src;
    alu_class_e alu_class;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic [2:0] funct3;
    logic       funct7_b5;
    word_t      imm;
    logic       ebreak;
  } ctrl_t;

  // Program load port, one word per strobe
  typedef struct packed {
    logic               en;
    logic [imem_aw-1:0] addr;
    logic [31:0]        data;
  } imem_wr_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    reg_idx_t rd;
    word_t    data;
  } wb_trace_t;

endpackage

/* rtl/rv_pc.sv */
module rv_pc (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          halt,
  output rv_pkg::word_t pc
);

  rv_pkg::word_t pc_next;

  // Sequential fetch only, no branch targets
  assign pc_next = pc + rv_pkg::pc_step;

  // Hold on halt so the EBREAK stays at pc
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (!halt) begin
      pc <= pc_next;
    end
  end

endmodule

/* rtl/rv_imem.sv */
module rv_imem (
  input  logic                       clk,
  input  rv_pkg::imem_wr_t           load,
  input  logic [rv_pkg::imem_aw-1:0] addr,
  output logic [31:0]                instr
);

  // Word addressed storage
  logic [31:0] mem [rv_pkg::imem_depth];

  // --------------------
  // Load port
  // --------------------

  // Works regardless of rst_n so a program can go in during reset
  always_ff @(posedge clk) begin
    if (load.en) begin
      mem[load.addr] <= load.data;
    end
  end

  // --------------------
  // Fetch port
  // --------------------

  // Asynchronous read, the core is single cycle
  assign instr = mem[addr];

endmodule

/* rtl/rv_idec.sv */
module rv_idec (
  input  logic [31:0]   instr,
  output rv_pkg::ctrl_t ctrl
);

  logic [6:0]    opcode;
  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_u;
  logic          is_ebreak;

  assign opcode = instr[6:0];

  // --------------------
  // Immediates
  // --------------------

  // I-type, sign extended from bit 31
  assign imm_i = {{(rv_pkg::xlen - 12){instr[31]}}, instr[31:20]};

  // U-type, upper 20 bits with zero fill
  assign imm_u = {instr[31:12], 12'b0};

  assign is_ebreak = (instr == rv_pkg::instr_ebreak);

  // --------------------
  // Control
  // --------------------

  always_comb begin
    // Fixed fields, same position in every format used here
    ctrl.rd        = instr[11:7];
    ctrl.rs1       = instr[19:15];
    ctrl.rs2       = instr[24:20];
    ctrl.funct3    = instr[14:12];
    ctrl.funct7_b5 = instr[30];
    ctrl.ebreak    = is_ebreak;

    // Defaults give a no-op
    ctrl.reg_write = 1'b0;
    ctrl.b_is_imm  = 1'b0;
    ctrl.a_src     = rv_pkg::a_rs1;
    ctrl.alu_class = rv_pkg::cls_add_only;
    ctrl.imm       = imm_i;

    case (opcode)
      rv_pkg::opc_op: begin
        ctrl.reg_write = 1'b1;
        ctrl.b_is_imm  = 1'b0;
        ctrl.alu_class = rv_pkg::cls_reg_op;
      end

      rv_pkg::opc_op_imm: begin
        ctrl.reg_write = 1'b1;
        ctrl.b_is_imm  = 1'b1;
        ctrl.alu_class = rv_pkg::cls_imm_op;
        ctrl.imm       = imm_i;
      end

      // rd = 0 + imm_u
      rv_pkg::opc_lui: begin
        ctrl.reg_write = 1'b1;
        ctrl.b_is_imm  = 1'b1;
        ctrl.a_src     = rv_pkg::a_zero;
        ctrl.alu_class = rv_pkg::cls_add_only;
        ctrl.imm       = imm_u;
      end

      // rd = pc + imm_u
      rv_pkg::opc_auipc: begin
        ctrl.reg_write = 1'b1;
        ctrl.b_is_imm  = 1'b1;
        ctrl.a_src     = rv_pkg::a_pc;
        ctrl.alu_class = rv_pkg::cls_add_only;
        ctrl.imm       = imm_u;
      end

      // Loads, stores, branches, SYSTEM and the rest
      default: begin
        ctrl.reg_write = 1'b0;
      end
    endcase
  end

endmodule

/* rtl/rv_alu_dec.sv */
module rv_alu_dec (
  input  rv_pkg::alu_class_e alu_class,
  input  logic [2:0]         funct3,
  input  logic               funct7_b5,
  output rv_pkg::alu_op_e    alu_op
);

  logic is_sub;
  logic is_sra;

  // Bit 30 only means SUB for register ops; ADDI uses it as imm data
  assign is_sub = (alu_class == rv_pkg::cls_reg_op) && funct7_b5;

  // Both classes carry the arithmetic shift flag in bit 30
  assign is_sra = funct7_b5;

  always_comb begin
    alu_op = rv_pkg::alu_add;

    if (alu_class != rv_pkg::cls_add_only) begin
      case (funct3)
        3'b000: begin
          alu_op = is_sub ? rv_pkg::alu_sub : rv_pkg::alu_add;
        end
        3'b001: begin
          alu_op = rv_pkg::alu_sll;
        end
        3'b010: begin
          alu_op = rv_pkg::alu_slt;
        end
        3'b011: begin
          alu_op = rv_pkg::alu_sltu;
        end
        3'b100: begin
          alu_op = rv_pkg::alu_xor;
        end
        3'b101: begin
          alu_op = is_sra ? rv_pkg::alu_sra : rv_pkg::alu_srl;
        end
        3'b110: begin
          alu_op = rv_pkg::alu_or;
        end
        default: begin
          alu_op = rv_pkg::alu_and;
        end
      endcase
    end
  end

endmodule

/* rtl/rv_regfile.sv */
module rv_regfile (
  input  logic             clk,
  input  logic             rst_n,
  input  rv_pkg::reg_idx_t rs1_addr,
  input  rv_pkg::reg_idx_t rs2_addr,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  input  logic             rd_en,
  input  rv_pkg::reg_idx_t rd_addr,
  input  rv_pkg::word_t    rd_data
);

  rv_pkg::word_t regs [rv_pkg::nregs];

  // --------------------
  // Write port
  // --------------------

  // x0 is never written, so it keeps its reset value of zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < rv_pkg::nregs; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_en && (rd_addr != '0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // --------------------
  // Read ports
  // --------------------

  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

/* rtl/rv_alu.sv */
module rv_alu (
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::alu_op_e alu_op,
  output rv_pkg::word_t   result
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  // Shift amount from the low five bits only
  assign shamt = b[4:0];

  // Compare results for SLT and SLTU
  assign lt_s = $signed(a) < $signed(b);
  assign lt_u = a < b;

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add:  result = a + b;
      rv_pkg::alu_sub:  result = a - b;
      rv_pkg::alu_sll:  result = a << shamt;
      rv_pkg::alu_slt:  result = {{(rv_pkg::xlen - 1){1'b0}}, lt_s};
      rv_pkg::alu_sltu: result = {{(rv_pkg::xlen - 1){1'b0}}, lt_u};
      rv_pkg::alu_xor:  result = a ^ b;
      rv_pkg::alu_srl:  result = a >> shamt;
      // Sign bit fills from the left
      rv_pkg::alu_sra:  result = rv_pkg::word_t'($signed(a) >>> shamt);
      rv_pkg::alu_or:   result = a | b;
      rv_pkg::alu_and:  result = a & b;
      default:          result = '0;
    endcase
  end

endmodule

/* rtl/rv_core.sv */
module rv_core (
  input  logic              clk,
  input  logic              rst_n,
  input  rv_pkg::imem_wr_t  load,
  output rv_pkg::wb_trace_t trace,
  output logic              ebreak
);

  rv_pkg::word_t   pc;
  logic [31:0]     instr;
  rv_pkg::ctrl_t   ctrl;
  rv_pkg::alu_op_e alu_op;
  rv_pkg::word_t   rs1_data;
  rv_pkg::word_t   rs2_data;
  rv_pkg::word_t   alu_a;
  rv_pkg::word_t   alu_b;
  rv_pkg::word_t   alu_result;
  logic            halt;
  logic            rd_en;

  // --------------------
  // Fetch
  // --------------------

  rv_pc i_rv_pc (
    .clk  (clk),
    .rst_n(rst_n),
    .halt (halt),
    .pc   (pc)
  );

  rv_imem i_rv_imem (
    .clk  (clk),
    .load (load),
    .addr (pc[rv_pkg::imem_aw+1:2]),
    .instr(instr)
  );

  // --------------------
  // Decode
  // --------------------

  rv_idec i_rv_idec (
    .instr(instr),
    .ctrl (ctrl)
  );

  rv_alu_dec i_rv_alu_dec (
    .alu_class(ctrl.alu_class),
    .funct3   (ctrl.funct3),
    .funct7_b5(ctrl.funct7_b5),
    .alu_op   (alu_op)
  );

  // Halt and write are both off while in reset
  assign halt  = ctrl.ebreak && rst_n;
  assign rd_en = ctrl.reg_write && rst_n && !halt;

  rv_regfile i_rv_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1_addr(ctrl.rs1),
    .rs2_addr(ctrl.rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .rd_en   (rd_en),
    .rd_addr (ctrl.rd),
    .rd_data (alu_result)
  );

  // --------------------
  // Execute
  // --------------------

  // Operand A, zero for LUI and pc for AUIPC
  always_comb begin
    case (ctrl.a_src)
      rv_pkg::a_zero: alu_a = '0;
      rv_pkg::a_pc:   alu_a = pc;
      default:        alu_a = rs1_data;
    endcase
  end

  assign alu_b = ctrl.b_is_imm ? ctrl.imm : rs2_data;

  rv_alu i_rv_alu (
    .a     (alu_a),
    .b     (alu_b),
    .alu_op(alu_op),
    .result(alu_result)
  );

  // Write-back trace, same cycle as the register write it shows
  assign trace.valid = rd_en;
  assign trace.pc    = pc;
  assign trace.rd    = ctrl.rd;
  assign trace.data  = alu_result;

  assign ebreak = halt;

endmodule

/* test/rv_clk_gen.sv */
module rv_clk_gen (
  output logic clk
);

  // Period 20, first rising edge at 10
  initial clk = 1'b0;

  always #10 clk = ~clk;

endmodule

/* test/rv_core_tb.sv */
module rv_core_tb;

  localparam logic [31:0] ebreak_word = 32'h0010_0073;
  localparam int reset_cycles = 5;

  // One program word and the write-back it should cause
  typedef struct packed {
    logic [31:0]   instr;
    logic          wr;
    rv_pkg::word_t value;
  } entry_t;

  logic              clk;
  logic              rst_n;
  rv_pkg::imem_wr_t  load;
  rv_pkg::wb_trace_t trace;
  logic              ebreak;

  entry_t        prog [$];
  string         names [$];
  // Reference register values updated as rows are added
  rv_pkg::word_t gold [32];
  int            cycles = 0;
  int            cycle_limit = 0;

  rv_clk_gen i_rv_clk_gen (
    .clk(clk)
  );

  rv_core i_rv_core (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (load),
    .trace (trace),
    .ebreak(ebreak)
  );

  // --------------------
  // Program table
  // --------------------

  function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic rv_pkg::word_t sext12(int imm);
    return {{20{imm[11]}}, imm[11:0]};
  endfunction

  task automatic add_row(string name, logic [31:0] instr, logic wr, rv_pkg::word_t value);
    prog.push_back(entry_t'{instr, wr, value});
    names.push_back(name);
    // x0 stays zero in the model too
    if (wr && instr[11:7] != 5'd0) begin
      gold[instr[11:7]] = value;
    end
  endtask

  task automatic build_program();
    int imm [4];
    gold = '{default: '0};
    foreach (imm[i]) begin
      imm[i] = $urandom();
    end
    add_row("addi x1", i_type(imm[0], 0, 0, 1), 1'b1, sext12(imm[0]));
    add_row("addi x2", i_type(imm[1], 0, 0, 2), 1'b1, sext12(imm[1]));
    add_row("addi x3", i_type(imm[2], 1, 0, 3), 1'b1, gold[1] + sext12(imm[2]));
    add_row("xori x4", i_type(imm[3], 2, 4, 4), 1'b1, gold[2] ^ sext12(imm[3]));
    add_row("ori x5", i_type(12'h0f0, 1, 6, 5), 1'b1, gold[1] | 32'h0f0);
    add_row("andi x6", i_type(12'h7ff, 2, 7, 6), 1'b1, gold[2] & 32'h7ff);
    // Negative operand and a small shift amount
    add_row("addi x7", i_type(12'hfec, 0, 0, 7), 1'b1, 32'hffff_ffec);
    add_row("addi x8", i_type(3, 0, 0, 8), 1'b1, 32'd3);
    add_row("add x9", r_type(0, 2, 1, 0, 9), 1'b1, gold[1] + gold[2]);
    add_row("sub x10", r_type(32, 7, 1, 0, 10), 1'b1, gold[1] - gold[7]);
    add_row("sll x11", r_type(0, 8, 3, 1, 11), 1'b1, gold[3] << gold[8][4:0]);
    add_row("srl x12", r_type(0, 8, 7, 5, 12), 1'b1, gold[7] >> gold[8][4:0]);
    // -20 shifted right by 3 with sign fill is -3
    add_row("sra x13", r_type(32, 8, 7, 5, 13), 1'b1, 32'hffff_fffd);
    add_row("slt x14", r_type(0, 1, 7, 2, 14), 1'b1,
            {31'd0, $signed(gold[7]) < $signed(gold[1])});
    add_row("sltu x15", r_type(0, 1, 7, 3, 15), 1'b1, {31'd0, gold[7] < gold[1]});
    // LUI x16 and AUIPC x17 with the immediate in bits 31:12
    add_row("lui x16", 32'habcd_e837, 1'b1, 32'habcd_e000);
    add_row("auipc x17", 32'h0001_2897, 1'b1, 32'h0001_2000 + 4 * prog.size());
    // Shows in the trace but x0 keeps zero
    add_row("addi x0", i_type(12'h123, 1, 0, 0), 1'b1, gold[1] + 32'h123);
    add_row("add x18", r_type(0, 2, 0, 0, 18), 1'b1, gold[0] + gold[2]);
    // SW x1, 0(x2)
    add_row("store no-op", 32'h0011_2023, 1'b0, '0);
    add_row("add x19", r_type(0, 17, 16, 0, 19), 1'b1, gold[16] + gold[17]);
    add_row("ebreak", ebreak_word, 1'b0, '0);
    // Words past the EBREAK would write x20 if the core fetched them
    for (int i = 0; i < 5; i++) begin
      add_row("halt hold", i_type(1, 0, 0, 20), 1'b0, '0);
    end
  endtask

  // --------------------
  // Checks
  // --------------------

  task automatic check_trace(string name, rv_pkg::wb_trace_t want, rv_pkg::wb_trace_t got);
    logic bad;
    // pc, rd and data only matter on a write
    bad = want.valid ? (got !== want) : (got.valid !== 1'b0);
    if (bad) begin
      // Field order is valid pc rd data
      $display("Fail %s: expected %0b %h x%0d %h, actual %0b %h x%0d %h", name,
               want.valid, want.pc, want.rd, want.data, got.valid, got.pc, got.rd, got.data);
      $display("Testbench failed");
      $fatal(1, "Trace mismatch");
    end
  endtask

  task automatic check_flag(string name, logic want, logic got);
    if (got !== want) begin
      $display("Fail %s: expected %0b, actual %0b", name, want, got);
      $display("Testbench failed");
      $fatal(1, "Flag mismatch");
    end
  endtask

  // Loading runs ahead of fetch so words past the reset window land before pc gets there
  task automatic load_program();
    rv_pkg::imem_wr_t wr;
    for (int i = 0; i < prog.size(); i++) begin
      @(posedge clk);
      #2;
      wr.en   = 1'b1;
      wr.addr = i[rv_pkg::imem_aw-1:0];
      wr.data = prog[i].instr;
      load    = wr;
    end
    @(posedge clk);
    #2;
    load = '0;
  endtask

  // Write enable and halt stay gated off while rst_n is low
  task automatic hold_reset();
    rv_pkg::wb_trace_t idle;
    idle = '0;
    repeat (reset_cycles - 1) begin
      @(negedge clk);
      check_trace("reset", idle, trace);
      check_flag("reset ebreak", 1'b0, ebreak);
    end
    @(posedge clk);
    #2;
    rst_n = 1'b1;
  endtask

  task automatic run_table();
    rv_pkg::wb_trace_t want;
    logic              halted;
    halted = 1'b0;
    for (int k = 0; k < prog.size(); k++) begin
      // Outputs are settled by the falling edge
      @(negedge clk);
      halted     = halted || (prog[k].instr == ebreak_word);
      want.valid = prog[k].wr;
      want.pc    = 4 * k;
      want.rd    = prog[k].instr[11:7];
      want.data  = prog[k].value;
      check_trace(names[k], want, trace);
      check_flag({names[k], " ebreak"}, halted, ebreak);
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the program never reached its end", cycles);
      $display("Testbench failed");
      $fatal(1, "Timeout");
    end
  end

  initial begin
    rst_n = 1'b0;
    load  = '0;
    void'($urandom(24885));
    build_program();
    // Table, reset and load cycles plus margin
    cycle_limit = prog.size() + reset_cycles + prog.size() + 20;
    fork
      load_program();
      begin
        hold_reset();
        run_table();
      end
    join
    $display("Testbench passed");
    $finish;
  end

endmodule

/* sources.f */
rtl/rv_pkg.sv
rtl/rv_pc.sv
rtl/rv_imem.sv
rtl/rv_idec.sv
rtl/rv_alu_dec.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_core.sv
test/rv_clk_gen.sv
test/rv_core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module rv_core_tb -f sources.f \
  -o rv_core_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0
